/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_bringup_levelshift
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED
FAIL_MSG  ?= CHECKS FAILED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: build
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
source/levelshift_pkg.sv
source/bringup_timebase.sv
source/pin_activity.sv
source/report_scanner.sv
source/uart_tx.sv
source/bringup_levelshift_top.sv
testbench/bringup_levelshift_chk.sv
testbench/tb_bringup_levelshift.sv

/* source/bringup_levelshift_top.sv */
// level shifter bring-up top with a pin activity report over UART and a probe output
`timescale 1ns/1ps

module bringup_levelshift_top import levelshift_pkg::*; (
	input  logic       clock,
	input  logic       rst_i,

	// monitored inputs
	input  logic [7:0] pa_i,
	input  logic [7:0] pd_i,
	input  logic       ppu2_hblank_i,
	input  logic       ppu2_vblank_i,
	input  logic       bodge1_i,
	input  logic       bodge2_i,

	output logic       bodge3_o,  // probe square wave
	output logic       uart_tx_o,

	// level shifter control
	output logic       lvl_pa_dir_o,
	output logic       lvl_pd_dir_o,
	output logic       lvl_va_dir_o,
	output logic       lvl_vd_dir_o,
	output logic       lvl_tst_dir_o,
	output logic       lvl_tst_oe_o
);

	logic [NUM_PINS-1:0] pins;
	logic [NUM_PINS-1:0] active;
	logic                dec_tick;
	logic                scan_tick;
	logic                uart_write;
	logic [7:0]          uart_data;
	logic                uart_busy;

	// report order from the package
	always_comb begin
		pins                   = '0;
		pins[PIN_PA_BASE +: 8] = pa_i;
		pins[PIN_PD_BASE +: 8] = pd_i;
		pins[PIN_HBLANK]       = ppu2_hblank_i;
		pins[PIN_VBLANK]       = ppu2_vblank_i;
		pins[PIN_BODGE1]       = bodge1_i;
		pins[PIN_BODGE2]       = bodge2_i;
	end

	// every shifter faces inward
	assign lvl_pa_dir_o  = LVL_DIR_INPUT;
	assign lvl_pd_dir_o  = LVL_DIR_INPUT;
	assign lvl_va_dir_o  = LVL_DIR_INPUT;
	assign lvl_vd_dir_o  = LVL_DIR_INPUT;
	assign lvl_tst_dir_o = LVL_DIR_INPUT;
	assign lvl_tst_oe_o  = 1'b0; // active low enable

	bringup_timebase timebase0 (
		.clock       (clock),
		.rst_i       (rst_i),
		.dec_tick_o  (dec_tick),
		.scan_tick_o (scan_tick),
		.drive_o     (bodge3_o)
	);

	pin_activity activity0 (
		.clock      (clock),
		.rst_i      (rst_i),
		.pins_i     (pins),
		.dec_tick_i (dec_tick),
		.active_o   (active)
	);

	report_scanner scanner0 (
		.clock       (clock),
		.rst_i       (rst_i),
		.scan_tick_i (scan_tick),
		.active_i    (active),
		.busy_i      (uart_busy),
		.write_o     (uart_write),
		.data_o      (uart_data)
	);

	uart_tx uart_tx0 (
		.clock   (clock),
		.rst_i   (rst_i),
		.write_i (uart_write),
		.data_i  (uart_data),
		.busy_o  (uart_busy),
		.tx_o    (uart_tx_o)
	);

endmodule

/* source/bringup_timebase.sv */
// monitor timebase with decay tick, scan tick and probe square wave
`timescale 1ns/1ps

module bringup_timebase import levelshift_pkg::*; (
	input  logic clock,
	input  logic rst_i,
	output logic dec_tick_o,
	output logic scan_tick_o,
	output logic drive_o
);

	logic [DEC_W-1:0]   dec_cnt;
	logic [SCAN_W-1:0]  scan_cnt;
	logic [DRIVE_W-1:0] drive_cnt;

	always_ff @(posedge clock) begin
		if (rst_i) begin
			dec_cnt     <= '0;
			scan_cnt    <= '0;
			drive_cnt   <= '0;
			dec_tick_o  <= 1'b0;
			scan_tick_o <= 1'b0;
			drive_o     <= 1'b0; // probe starts low
		end else begin
			dec_tick_o <= (dec_cnt == DEC_W'(DEC_PERIOD - 1));
			if (dec_cnt == DEC_W'(DEC_PERIOD - 1))
				dec_cnt <= '0;
			else
				dec_cnt <= dec_cnt + 1'b1;

			scan_tick_o <= (scan_cnt == SCAN_W'(SCAN_PERIOD - 1));
			if (scan_cnt == SCAN_W'(SCAN_PERIOD - 1))
				scan_cnt <= '0;
			else
				scan_cnt <= scan_cnt + 1'b1;

			if (drive_cnt == DRIVE_W'(DRIVE_HALF - 1)) begin
				drive_cnt <= '0;
				drive_o   <= ~drive_o; // half period done
			end else begin
				drive_cnt <= drive_cnt + 1'b1;
			end
		end
	end

endmodule

/* source/levelshift_pkg.sv */
// level shifter bring-up constants for pin order, timing and report characters
package levelshift_pkg;

	// monitored pins in report order
	localparam int NUM_PINS    = 20;
	localparam int PIN_PA_BASE = 0;  // pa[7:0]
	localparam int PIN_PD_BASE = 8;  // pd[7:0]
	localparam int PIN_HBLANK  = 16;
	localparam int PIN_VBLANK  = 17;
	localparam int PIN_BODGE1  = 18;
	localparam int PIN_BODGE2  = 19;

	localparam int DEC_PERIOD      = 500;  // clocks per decay tick
	localparam int HOLD_TICKS      = 3;    // decay ticks a flag survives
	localparam int SCAN_PERIOD     = 4000; // clocks per report
	localparam int DRIVE_HALF      = 40;   // probe half period
	localparam int CLOCKS_PER_BAUD = 8;
	localparam int UART_FRAME_BITS = 10;   // start, 8 data, stop

	// counter widths
	localparam int DEC_W   = $clog2(DEC_PERIOD);
	localparam int SCAN_W  = $clog2(SCAN_PERIOD);
	localparam int DRIVE_W = $clog2(DRIVE_HALF);
	localparam int HOLD_W  = $clog2(HOLD_TICKS + 1);
	localparam int BAUD_W  = $clog2(CLOCKS_PER_BAUD);
	localparam int BIT_W   = $clog2(UART_FRAME_BITS);
	localparam int IDX_W   = $clog2(NUM_PINS + 2); // pins plus CR and LF

	localparam logic [7:0] CHAR_ACTIVE = 8'h31; // '1'
	localparam logic [7:0] CHAR_QUIET  = 8'h30; // '0'
	localparam logic [7:0] CHAR_CR     = 8'h0d;
	localparam logic [7:0] CHAR_LF     = 8'h0a;

	localparam logic LVL_DIR_INPUT = 1'b1; // shifter direction for B to A
endpackage

/* source/pin_activity.sv */
// per-pin activity detector with a hold counter that decays on ticks
`timescale 1ns/1ps

module pin_activity import levelshift_pkg::*; (
	input  logic                clock,
	input  logic                rst_i,
	input  logic [NUM_PINS-1:0] pins_i,
	input  logic                dec_tick_i,
	output logic [NUM_PINS-1:0] active_o
);

	logic [NUM_PINS-1:0] sync1;
	logic [NUM_PINS-1:0] sync2;
	logic [NUM_PINS-1:0] prev;
	logic [NUM_PINS-1:0] edge_det;
	logic [HOLD_W-1:0]   hold_cnt [NUM_PINS];

	// two-flop synchronizer then the edge register
	always_ff @(posedge clock) begin
		sync1 <= pins_i;
		sync2 <= sync1;
		prev  <= sync2; // edge register
	end

	assign edge_det = sync2 ^ prev; // either direction

	always_ff @(posedge clock) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_PINS; i++)
				hold_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_PINS; i++) begin
				if (edge_det[i])
					hold_cnt[i] <= HOLD_W'(HOLD_TICKS); // edge beats a tick
				else if (dec_tick_i && hold_cnt[i] != '0)
					hold_cnt[i] <= hold_cnt[i] - 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_PINS; i++)
			active_o[i] = (hold_cnt[i] != '0);
	end

endmodule

/* source/report_scanner.sv */
// report scanner that snapshots the activity flags and sends them as one text line
`timescale 1ns/1ps

module report_scanner import levelshift_pkg::*; (
	input  logic                clock,
	input  logic                rst_i,
	input  logic                scan_tick_i,
	input  logic [NUM_PINS-1:0] active_i,
	input  logic                busy_i,
	output logic                write_o,
	output logic [7:0]          data_o
);

	logic                reporting;
	logic [IDX_W-1:0]    idx;  // character position in the line
	logic [NUM_PINS-1:0] snap;

	// one byte per free transmitter slot
	assign write_o = reporting && !busy_i;

	always_comb begin
		if (idx < IDX_W'(NUM_PINS))
			data_o = snap[idx] ? CHAR_ACTIVE : CHAR_QUIET;
		else if (idx == IDX_W'(NUM_PINS))
			data_o = CHAR_CR;
		else
			data_o = CHAR_LF;
	end

	always_ff @(posedge clock) begin
		if (rst_i) begin
			reporting <= 1'b0;
			idx       <= '0;
		end else if (!reporting) begin
			if (scan_tick_i) begin
				reporting <= 1'b1; // first byte goes out next cycle
				idx       <= '0;
			end
		end else if (write_o) begin
			if (idx == IDX_W'(NUM_PINS + 1)) begin
				reporting <= 1'b0; // line ends after the LF
				idx       <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// flags frozen for the whole line
	always_ff @(posedge clock) begin
		if (!reporting && scan_tick_i)
			snap <= active_i;
	end

endmodule

/* source/uart_tx.sv */
// 8N1 serial transmitter that sends LSB first
`timescale 1ns/1ps

module uart_tx import levelshift_pkg::*; (
	input  logic       clock,
	input  logic       rst_i,
	input  logic       write_i,
	input  logic [7:0] data_i,
	output logic       busy_o,
	output logic       tx_o
);

	logic [BAUD_W-1:0] baud_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	logic [8:0]        shift; // data bits then stop bit

	always_ff @(posedge clock) begin
		if (rst_i) begin
			busy_o   <= 1'b0;
			tx_o     <= 1'b1; // line idles high
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (write_i) begin
			// new frame starts with the start bit
			busy_o   <= 1'b1;
			tx_o     <= 1'b0; // start bit
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else if (busy_o) begin
			if (baud_cnt == BAUD_W'(CLOCKS_PER_BAUD - 1)) begin
				baud_cnt <= '0;
				if (bit_cnt == BIT_W'(UART_FRAME_BITS - 1)) begin
					busy_o <= 1'b0; // stop bit finished
					tx_o   <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					tx_o    <= shift[0];
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (write_i)
			shift <= {1'b1, data_i};
		else if (busy_o && baud_cnt == BAUD_W'(CLOCKS_PER_BAUD - 1))
			shift <= {1'b1, shift[8:1]}; // next bit down to lsb
	end

endmodule

/* testbench/bringup_levelshift_chk.sv */
// UART checker bound into the transmitter for writes, frame length and idle line
`timescale 1ns/1ps

module bringup_levelshift_chk import levelshift_pkg::*; (
	input logic clock,
	input logic rst_i,
	input logic write_i,
	input logic busy_i,
	input logic tx_i
);

	localparam int FRAME_CLKS = UART_FRAME_BITS * CLOCKS_PER_BAUD;

	int busy_len;  // sampled busy cycles of the current frame
	int write_fails = 0;
	int len_fails = 0;
	int idle_fails = 0;
	int fail_count;

	assign fail_count = write_fails + len_fails + idle_fails;

	always_ff @(posedge clock) begin
		if (rst_i || !busy_i)
			busy_len <= 0;
		else
			busy_len <= busy_len + 1;
	end

	write_when_free: assert property (@(posedge clock) disable iff (rst_i)
		write_i |-> !busy_i)
	else begin
		write_fails = write_fails + 1;
		$error("write strobe while the transmitter is busy");
	end

	// while busy the count stays below a frame and it equals a frame when busy drops
	frame_length: assert property (@(posedge clock) disable iff (rst_i)
		busy_i ? (busy_len < FRAME_CLKS) : (!$fell(busy_i) || busy_len == FRAME_CLKS))
	else begin
		len_fails = len_fails + 1;
		$error("busy length differs from one frame, %0d cycles", busy_len);
	end

	idle_high: assert property (@(posedge clock) disable iff (rst_i)
		!busy_i |-> tx_i)
	else begin
		idle_fails = idle_fails + 1;
		$error("tx line low while the transmitter is idle");
	end

endmodule

bind uart_tx bringup_levelshift_chk chk0 (
	.clock   (clock),
	.rst_i   (rst_i),
	.write_i (write_i),
	.busy_i  (busy_o),
	.tx_i    (tx_o)
);

/* testbench/tb_bringup_levelshift.sv */
// testbench for the level shifter bring-up monitor with random pins, UART receiver and model
`timescale 1ns/1ps

module tb_bringup_levelshift import levelshift_pkg::*; ();

	localparam int HALF_CLK     = 50;
	localparam int DRIVE_DLY    = 5;
	localparam int RESET_CYCLES = 16;
	localparam int NEVER        = -1000000;
	localparam int SYNC_LAT     = 4;  // pin change to snapshot register
	localparam int LINE_LEN     = NUM_PINS + 2;
	localparam int FRAME_CLKS   = UART_FRAME_BITS * CLOCKS_PER_BAUD;

	logic                clock;
	logic                rst_i;
	logic [NUM_PINS-1:0] pins = '0;
	logic                bodge3_o, uart_tx_o;
	logic                lvl_pa_dir_o, lvl_pd_dir_o, lvl_va_dir_o;
	logic                lvl_vd_dir_o, lvl_tst_dir_o, lvl_tst_oe_o;

	int          cycle = 0;
	int          release_cycle = 0;
	int          last_change [NUM_PINS] = '{default: NEVER};
	int          start_last [NUM_PINS];  // last_change seen at a start bit
	int          line_last [NUM_PINS];
	logic [7:0]  line_buf [LINE_LEN];
	int          line_start = 0;
	int          prev_start = -1;
	int          mode = 0;  // 0 still, 1 random, 2 single pin
	int          target = 0;
	logic [NUM_PINS-1:0] quiet_mask = '0;
	logic [31:0] rng = 32'd77;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_checks = 0;
	int          test_errors = 0;
	bit          aborted = 0;

	bringup_levelshift_top DUT (
		.clock         (clock),
		.rst_i         (rst_i),
		.pa_i          (pins[PIN_PA_BASE +: 8]),
		.pd_i          (pins[PIN_PD_BASE +: 8]),
		.ppu2_hblank_i (pins[PIN_HBLANK]),
		.ppu2_vblank_i (pins[PIN_VBLANK]),
		.bodge1_i      (pins[PIN_BODGE1]),
		.bodge2_i      (pins[PIN_BODGE2]),
		.bodge3_o      (bodge3_o),
		.uart_tx_o     (uart_tx_o),
		.lvl_pa_dir_o  (lvl_pa_dir_o),
		.lvl_pd_dir_o  (lvl_pd_dir_o),
		.lvl_va_dir_o  (lvl_va_dir_o),
		.lvl_vd_dir_o  (lvl_vd_dir_o),
		.lvl_tst_dir_o (lvl_tst_dir_o),
		.lvl_tst_oe_o  (lvl_tst_oe_o)
	);

	initial begin
		clock = 1'b0;
		forever #(HALF_CLK) clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic toggle_pin(input int p);
		pins[p] = ~pins[p];
		last_change[p] = cycle;  // model keeps the cycle of the change
	endtask

	// pin stimulus a little after each rising edge
	always @(posedge clock) begin
		#(DRIVE_DLY);
		if (mode == 1) begin
			rng = xorshift(rng);
			if (cycle % 3000 == 0)
				quiet_mask = rng[NUM_PINS-1:0];  // some pins rest for a stretch
			else if (rng[5:0] == 6'd0 && !quiet_mask[int'(rng[31:8]) % NUM_PINS])
				toggle_pin(int'(rng[31:8]) % NUM_PINS);
		end else if (mode == 2 && cycle % 64 == 0) begin
			toggle_pin(target);
		end
	end

	task automatic check(input string what, input int got, input int exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic start_test();
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s: %0d checks, %0d errors", name, checks - test_checks,
			errors - test_errors);
	endtask

	// samples each bit in its middle on falling clock edges
	task automatic recv_byte(input int limit, output logic [7:0] data, output bit ok);
		int n;
		int b;
		bit seen;
		ok = 1'b0;
		data = '0;
		seen = 1'b0;
		if (aborted)
			return;
		for (n = 0; n < limit && !seen; n++) begin
			@(negedge clock);
			seen = (uart_tx_o == 1'b0);
		end
		if (!seen) begin
			$display("Timeout: no start bit on uart_tx_o within %0d cycles", limit);
			aborted = 1'b1;
			return;
		end
		line_start = cycle;
		start_last = last_change;
		repeat (CLOCKS_PER_BAUD / 2) @(negedge clock);
		check("start bit", int'(uart_tx_o), 0);
		for (b = 0; b < 8; b++) begin
			repeat (CLOCKS_PER_BAUD) @(negedge clock);
			data[b] = uart_tx_o;
		end
		repeat (CLOCKS_PER_BAUD) @(negedge clock);
		check("stop bit", int'(uart_tx_o), 1);
		ok = 1'b1;
	endtask

	task automatic recv_report(output bit ok);
		logic [7:0] ch;
		int i;
		int first;
		recv_byte(SCAN_PERIOD + 200, ch, ok);
		if (!ok)
			return;
		first = line_start;
		line_last = start_last;
		line_buf[0] = ch;
		if (prev_start >= 0)
			check("cycles between reports", first - prev_start, SCAN_PERIOD);
		prev_start = first;
		for (i = 1; i < LINE_LEN && ok; i++) begin
			recv_byte(2 * FRAME_CLKS, ch, ok);
			line_buf[i] = ch;
		end
		line_start = first;
	endtask

	task automatic check_framing();
		int i;
		for (i = 0; i < NUM_PINS; i++)
			check("report character is 0 or 1",
				int'(line_buf[i] == CHAR_ACTIVE || line_buf[i] == CHAR_QUIET), 1);
		check("carriage return", int'(line_buf[NUM_PINS]), int'(CHAR_CR));
		check("line feed", int'(line_buf[NUM_PINS + 1]), int'(CHAR_LF));
	endtask

	// snapshot is one cycle before the first start bit
	task automatic check_model();
		int i;
		int age;
		for (i = 0; i < NUM_PINS; i++) begin
			age = line_start - 1 - line_last[i];
			if (age >= SYNC_LAT && age <= DEC_PERIOD * (HOLD_TICKS - 1))
				check($sformatf("pin %0d changed %0d cycles before snapshot", i, age),
					int'(line_buf[i]), int'(CHAR_ACTIVE));
			else if (age > DEC_PERIOD * (HOLD_TICKS + 1))
				check($sformatf("pin %0d quiet for %0d cycles", i, age),
					int'(line_buf[i]), int'(CHAR_QUIET));
		end
	endtask

	initial begin
		bit ok;
		int n;
		int p;
		int i;
		rst_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DLY);
		rst_i = 1'b0;
		release_cycle = cycle;

		start_test();
		for (n = 0; n < 8 * DRIVE_HALF; n++) begin
			@(negedge clock);
			check("probe level", int'(bodge3_o), ((cycle - release_cycle) / DRIVE_HALF) % 2);
			check("idle uart line", int'(uart_tx_o), 1);
		end
		finish_test("probe square wave");

		start_test();
		check("pa direction", int'(lvl_pa_dir_o), int'(LVL_DIR_INPUT));
		check("pd direction", int'(lvl_pd_dir_o), int'(LVL_DIR_INPUT));
		check("va direction", int'(lvl_va_dir_o), int'(LVL_DIR_INPUT));
		check("vd direction", int'(lvl_vd_dir_o), int'(LVL_DIR_INPUT));
		check("tst direction", int'(lvl_tst_dir_o), int'(LVL_DIR_INPUT));
		check("tst output enable", int'(lvl_tst_oe_o), 0);
		recv_report(ok);
		if (ok) begin
			check("first start bit cycle", line_start - release_cycle, SCAN_PERIOD + 2);
			check_framing();
		end
		finish_test("idle outputs and first report");

		start_test();
		mode = 1;
		for (n = 0; n < 8 && !aborted; n++) begin
			recv_report(ok);
			if (ok) begin
				check_framing();
				check_model();
			end
		end
		finish_test("random activity and decay");

		start_test();
		for (p = 0; p < NUM_PINS && !aborted; p++) begin
			mode = 2;
			target = p;
			recv_report(ok);  // settling line checked against the model only
			if (ok)
				check_model();
			recv_report(ok);
			if (ok) begin
				check_framing();
				for (i = 0; i < NUM_PINS; i++)
					check($sformatf("pin %0d while only pin %0d toggles", i, p),
						int'(line_buf[i]), int'(i == p ? CHAR_ACTIVE : CHAR_QUIET));
			end
		end
		finish_test("report order");

		check("assertion failures", DUT.uart_tx0.chk0.fail_count, 0);
		$display("summary: %0d tests, %0d checks, %0d errors%s", tests, checks, errors,
			aborted ? ", run stopped by a timeout" : "");
		if (errors == 0 && !aborted)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
